// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = pkt_gen_tb
FILELIST = project.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/pkt_gen_pkg.sv
//////////////////////////////
// Register map, stream widths and flow definition types
// Shared by all blocks of the test-frame generator
//////////////////////////////
package pkt_gen_pkg;

    localparam int reg_w          = 32;
    localparam int addr_w         = 5;
    localparam int data_bytes     = 8;
    localparam int flow_def_words = 5;

    //////////////////////////////
    // Register word addresses
    //////////////////////////////

    localparam logic [addr_w-1:0] addr_params        = 5'd0;
    localparam logic [addr_w-1:0] addr_tx_con        = 5'd1;
    localparam logic [addr_w-1:0] addr_cntr_con      = 5'd2;
    localparam logic [addr_w-1:0] addr_pkt_cnt0      = 5'd4;
    localparam logic [addr_w-1:0] addr_pkt_cnt1      = 5'd5;
    localparam logic [addr_w-1:0] addr_byte_cnt0     = 5'd6;
    localparam logic [addr_w-1:0] addr_byte_cnt1     = 5'd7;
    localparam logic [addr_w-1:0] addr_flow_def_con  = 5'd8;
    localparam logic [addr_w-1:0] addr_last_flow     = 5'd9;
    // First of flow_def_words staging words
    localparam logic [addr_w-1:0] addr_flow_def_data = 5'd12;

    //////////////////////////////
    // Flow definition
    //////////////////////////////

    typedef struct packed {
        logic [47:0] mac_da;
        logic [47:0] mac_sa;
        logic [15:0] ether_type;
        // Whole frame in bytes, header included
        logic [15:0] frame_len;
        logic [7:0]  payload_value;
        logic [23:0] pad;
    } flow_def_t;

    // Word 0 holds the top 32 bits of the definition
    typedef union packed {
        flow_def_t                            fields;
        logic [0:flow_def_words-1][reg_w-1:0] words;
    } flow_def_u;

endpackage

// File: flow/flow_sched.sv
//////////////////////////////
// Round-robin flow scheduler with finite packet budget
//////////////////////////////
module flow_sched #(
    parameter  int NUM_FLOWS = 10,
    localparam int flow_w    = $clog2(NUM_FLOWS)
) (
    input  logic              avmm_clk_ifc,
    input  logic              rst,
    input  logic              tx_enable,
    input  logic              tx_finite,
    input  logic [27:0]       tx_count,
    input  logic [flow_w-1:0] last_flow,
    input  logic              frame_busy,
    output logic              frame_start,
    output logic [flow_w-1:0] frame_flow
);
    logic              enable_q;
    logic              enable_rise;
    logic [flow_w-1:0] cur_flow;
    logic [27:0]       remaining;
    logic              budget_ok;
    logic              issue;

    assign enable_rise = tx_enable && !enable_q;
    assign budget_ok   = !tx_finite || (remaining != '0);

    // Builder raises busy only on the edge after frame_start
    assign issue = tx_enable && !enable_rise && budget_ok && !frame_busy && !frame_start;

    always_ff @(posedge avmm_clk_ifc) begin
        if (rst) begin
            enable_q    <= 1'b0;
            frame_start <= 1'b0;
            frame_flow  <= '0;
            cur_flow    <= '0;
            remaining   <= '0;
        end else begin
            enable_q    <= tx_enable;
            frame_start <= issue;
            if (enable_rise) begin
                // New run starts at flow 0 with a fresh budget
                cur_flow  <= '0;
                remaining <= tx_count;
            end else if (issue) begin
                frame_flow <= cur_flow;
                if (cur_flow >= last_flow) begin
                    cur_flow <= '0;
                end else begin
                    cur_flow <= cur_flow + 1'b1;
                end
                if (tx_finite) begin
                    remaining <= remaining - 28'd1;
                end
            end
        end
    end

endmodule

// File: flow/flow_table.sv
//////////////////////////////
// Flow definition memory, one write port and a registered read port
//////////////////////////////
module flow_table #(
    parameter  int NUM_FLOWS = 10,
    localparam int flow_w    = $clog2(NUM_FLOWS)
) (
    input  logic                   avmm_clk_ifc,
    input  logic                   def_we,
    input  logic [flow_w-1:0]      def_addr,
    input  pkt_gen_pkg::flow_def_u def_data,
    input  logic [flow_w-1:0]      rd_addr,
    output pkt_gen_pkg::flow_def_t def_out
);
    import pkt_gen_pkg::*;

    flow_def_t mem [NUM_FLOWS];

    always_ff @(posedge avmm_clk_ifc) begin
        if (def_we) begin
            mem[def_addr] <= def_data.fields;
        end
        def_out <= mem[rd_addr];
    end

endmodule

// File: frame/frame_builder.sv
//////////////////////////////
// Builds one frame from a flow definition as 8-byte stream beats
//////////////////////////////
module frame_builder #(
    parameter  int NUM_FLOWS = 10,
    localparam int flow_w    = $clog2(NUM_FLOWS)
) (
    input  logic                                 avmm_clk_ifc,
    input  logic                                 rst,
    input  logic                                 frame_start,
    input  logic [flow_w-1:0]                    frame_flow,
    input  pkt_gen_pkg::flow_def_t               def_in,
    input  logic                                 tready,
    output logic                                 frame_busy,
    output logic [pkt_gen_pkg::data_bytes*8-1:0] tdata,
    output logic [pkt_gen_pkg::data_bytes-1:0]   tkeep,
    output logic                                 tvalid,
    output logic                                 tlast,
    output logic [flow_w-1:0]                    tuser
);
    import pkt_gen_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_load,
        st_send
    } state_t;

    state_t                  state;
    flow_def_t               def_q;
    logic [15:0]             offset;
    logic [111:0]            header;
    logic [data_bytes*8-1:0] beat_data;
    logic [data_bytes-1:0]   beat_keep;
    logic                    beat_last;
    logic                    load_beat;

    assign header    = {def_q.mac_da, def_q.mac_sa, def_q.ether_type};
    assign beat_last = (offset + 16'(data_bytes)) >= def_q.frame_len;
    assign load_beat = (state == st_load) || ((state == st_send) && tready && !tlast);

    // Header bytes first, MSB first, then payload fill
    always_comb begin
        int idx;
        for (int k = 0; k < data_bytes; k++) begin
            idx = int'(offset) + k;
            if (idx < 14) begin
                beat_data[8*k +: 8] = header[111 - 8*idx -: 8];
            end else begin
                beat_data[8*k +: 8] = def_q.payload_value;
            end
        end
    end

    always_comb begin
        beat_keep = '1;
        if (beat_last && (def_q.frame_len[2:0] != 3'd0)) begin
            beat_keep = data_bytes'((1 << def_q.frame_len[2:0]) - 1);
        end
    end

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (rst) begin
            state      <= st_idle;
            frame_busy <= 1'b0;
            tvalid     <= 1'b0;
            tlast      <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (frame_start) begin
                        frame_busy <= 1'b1;
                        state      <= st_fetch;
                    end
                end
                // Table read in flight
                st_fetch: state <= st_load;
                st_load:  state <= st_send;
                st_send: begin
                    if (tready && tlast) begin
                        frame_busy <= 1'b0;
                        state      <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
            if (load_beat) begin
                tvalid <= 1'b1;
                tlast  <= beat_last;
            end else if ((state == st_send) && tready) begin
                tvalid <= 1'b0;
                tlast  <= 1'b0;
            end
        end
    end

    always_ff @(posedge avmm_clk_ifc) begin
        if ((state == st_idle) && frame_start) begin
            tuser <= frame_flow;
        end
        if (state == st_fetch) begin
            def_q  <= def_in;
            offset <= '0;
        end
        if (load_beat) begin
            tdata  <= beat_data;
            tkeep  <= beat_keep;
            offset <= offset + 16'(data_bytes);
        end
    end

endmodule

// File: project.f
common/pkt_gen_pkg.sv
src/csr_regs.sv
src/tx_counters.sv
flow/flow_table.sv
flow/flow_sched.sv
frame/frame_builder.sv
src/pkt_gen_top.sv
sim/tb_clock.sv
sim/pkt_checker.sv
sim/pkt_gen_tb.sv

// File: sim/pkt_checker.sv
//////////////////////////////
// Stream monitor for the frame generator
// Compares beats with the expected frame bytes and keeps tallies
//////////////////////////////
module pkt_checker #(
    parameter  int NUM_FLOWS = 10,
    localparam int flow_w    = $clog2(NUM_FLOWS)
) (
    input  logic                   avmm_clk_ifc,
    input  logic                   rst,
    input  logic [63:0]            tdata,
    input  logic [7:0]             tkeep,
    input  logic                   tvalid,
    input  logic                   tready,
    input  logic                   tlast,
    input  logic [flow_w-1:0]      tuser,
    input  logic                   restart,
    input  logic [flow_w-1:0]      last_flow,
    input  pkt_gen_pkg::flow_def_t defs [NUM_FLOWS],
    output int                     pkt_count,
    output longint                 byte_count,
    output int                     frame_count,
    output logic                   frame_open,
    output int                     err_count,
    output int                     flow_seen [NUM_FLOWS]
);
    timeunit 1ns;
    timeprecision 100ps;
    import pkt_gen_pkg::*;

    flow_def_t         cur_def;
    logic [flow_w-1:0] cur_flow;
    logic [flow_w-1:0] exp_flow;
    int                offset;
    logic              stalled;
    logic [72+flow_w:0] held;

    // Byte i of a frame for flow definition d
    function automatic logic [7:0] expected_byte(input flow_def_t d, input int i);
        if (i < 6) begin
            return d.mac_da[47 - 8*i -: 8];
        end else if (i < 12) begin
            return d.mac_sa[47 - 8*(i-6) -: 8];
        end else if (i == 12) begin
            return d.ether_type[15:8];
        end else if (i == 13) begin
            return d.ether_type[7:0];
        end
        return d.payload_value;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic check_beat();
        logic [7:0] keep_exp;
        int         len;
        if (!frame_open) begin
            if (tuser != exp_flow) begin
                report_mismatch($sformatf("frame on flow %0d, expected flow %0d", tuser, exp_flow));
            end
            cur_flow   = tuser;
            cur_def    = defs[tuser];
            offset     = 0;
            frame_open = 1'b1;
            frame_count++;
            flow_seen[tuser]++;
            exp_flow = (exp_flow >= last_flow) ? '0 : exp_flow + 1'b1;
        end else if (tuser != cur_flow) begin
            report_mismatch($sformatf("tuser %0d inside frame of flow %0d", tuser, cur_flow));
        end
        len = int'(cur_def.frame_len);
        for (int k = 0; k < 8; k++) begin
            keep_exp[k] = (offset + k) < len;
            if (keep_exp[k] && (tdata[8*k +: 8] != expected_byte(cur_def, offset + k))) begin
                report_mismatch($sformatf("flow %0d byte %0d is %02h, expected %02h", cur_flow,
                    offset + k, tdata[8*k +: 8], expected_byte(cur_def, offset + k)));
            end
        end
        if (tkeep != keep_exp) begin
            report_mismatch($sformatf("tkeep %02h, expected %02h", tkeep, keep_exp));
        end
        if (tlast != ((offset + 8) >= len)) begin
            report_mismatch($sformatf("tlast %0b at byte offset %0d of %0d", tlast, offset, len));
        end
        byte_count += longint'($countones(keep_exp));
        if (tlast) begin
            pkt_count++;
            frame_open = 1'b0;
            if ((offset + $countones(tkeep)) != len) begin
                report_mismatch($sformatf("frame length %0d, expected %0d",
                    offset + $countones(tkeep), len));
            end
        end
        offset += 8;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge avmm_clk_ifc) begin
        if (rst) begin
            pkt_count   = 0;
            byte_count  = 0;
            frame_count = 0;
            frame_open  = 1'b0;
            err_count   = 0;
            exp_flow    = '0;
            stalled     = 1'b0;
            held        = '0;
            offset      = 0;
            for (int f = 0; f < NUM_FLOWS; f++) begin
                flow_seen[f] = 0;
            end
        end else begin
            if (restart) begin
                exp_flow = '0;
                for (int f = 0; f < NUM_FLOWS; f++) begin
                    flow_seen[f] = 0;
                end
            end
            if (stalled && (!tvalid || (held != {tdata, tkeep, tlast, tuser}))) begin
                report_mismatch("beat changed while stalled");
            end
            stalled = tvalid && !tready;
            held    = {tdata, tkeep, tlast, tuser};
            if (tvalid && tready) begin
                check_beat();
            end
        end
    end

endmodule

// File: sim/pkt_gen_tb.sv
//////////////////////////////
// Testbench top for the frame generator
// Loads flows over the register port and runs five tests
//////////////////////////////
module pkt_gen_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pkt_gen_pkg::*;

    localparam int NUM_FLOWS = 10;
    localparam int flow_w    = $clog2(NUM_FLOWS);
    // About 7.6 kB of frames, 8 bytes a beat, x4 for stalls, then wide margin
    localparam int max_cycles = 40000;

    logic                  avmm_clk_ifc;
    logic                  rst;
    logic [addr_w-1:0]     address;
    logic                  write;
    logic [reg_w-1:0]      writedata;
    logic                  read;
    logic [reg_w-1:0]      readdata;
    logic [63:0]           tdata;
    logic [7:0]            tkeep;
    logic                  tvalid;
    logic                  tlast;
    logic [flow_w-1:0]     tuser;
    logic                  tready = 1'b1;
    logic                  restart;
    logic [flow_w-1:0]     exp_last_flow;
    logic                  random_ready;
    flow_def_t             defs [NUM_FLOWS];
    int                    pkt_count;
    longint                byte_count;
    int                    frame_count;
    logic                  frame_open;
    int                    chk_errors;
    int                    flow_seen [NUM_FLOWS];
    int                    tb_errors = 0;
    int                    tests_failed = 0;
    int                    cycles = 0;
    integer                seed = 32'hb1a6_0805;

    tb_clock clock_i (
        .avmm_clk_ifc (avmm_clk_ifc),
        .rst          (rst)
    );

    pkt_gen_top #(
        .NUM_FLOWS (NUM_FLOWS)
    ) pkt_gen_top_i (
        .avmm_clk_ifc (avmm_clk_ifc),
        .rst          (rst),
        .address      (address),
        .write        (write),
        .writedata    (writedata),
        .read         (read),
        .readdata     (readdata),
        .tdata        (tdata),
        .tkeep        (tkeep),
        .tvalid       (tvalid),
        .tlast        (tlast),
        .tuser        (tuser),
        .tready       (tready)
    );

    pkt_checker #(
        .NUM_FLOWS (NUM_FLOWS)
    ) checker_i (
        .avmm_clk_ifc (avmm_clk_ifc),
        .rst          (rst),
        .tdata        (tdata),
        .tkeep        (tkeep),
        .tvalid       (tvalid),
        .tready       (tready),
        .tlast        (tlast),
        .tuser        (tuser),
        .restart      (restart),
        .last_flow    (exp_last_flow),
        .defs         (defs),
        .pkt_count    (pkt_count),
        .byte_count   (byte_count),
        .frame_count  (frame_count),
        .frame_open   (frame_open),
        .err_count    (chk_errors),
        .flow_seen    (flow_seen)
    );

    always @(posedge avmm_clk_ifc) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        tready <= random_ready ? rnd[0] : 1'b1;
    end

    always @(posedge avmm_clk_ifc) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////
    // Bus and test helpers
    //////////////////////////////

    task automatic write_reg(input logic [addr_w-1:0] a, input logic [reg_w-1:0] d);
        @(posedge avmm_clk_ifc);
        address   <= a;
        writedata <= d;
        write     <= 1'b1;
        @(posedge avmm_clk_ifc);
        write <= 1'b0;
    endtask

    task automatic read_reg(input logic [addr_w-1:0] a, output logic [reg_w-1:0] d);
        @(posedge avmm_clk_ifc);
        address <= a;
        read    <= 1'b1;
        @(posedge avmm_clk_ifc);
        read <= 1'b0;
        @(posedge avmm_clk_ifc);
        d = readdata;
    endtask

    task automatic flag_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        tb_errors++;
    endtask

    function automatic flow_def_t make_def(input int f);
        flow_def_t d;
        d.mac_da        = 48'h02_11_22_33_44_00 + 48'(f * 17);
        d.mac_sa        = 48'h0a_1b_2c_3d_4e_00 + 48'(f);
        d.ether_type    = 16'h88b5 + 16'(f);
        // 64 to 199 bytes, most not a multiple of 8
        d.frame_len     = 16'(64 + 15 * f);
        d.payload_value = 8'hc0 + 8'(f);
        d.pad           = '0;
        return d;
    endfunction

    task automatic load_flows();
        flow_def_u u;
        for (int f = 0; f < NUM_FLOWS; f++) begin
            u.fields = defs[f];
            for (int w = 0; w < flow_def_words; w++) begin
                write_reg(addr_flow_def_data + addr_w'(w), u.words[w]);
            end
            write_reg(addr_flow_def_con, (32'(f) << 8) | 32'd1);
        end
    endtask

    task automatic start_run(input logic [flow_w-1:0] last, input logic finite,
                             input logic [27:0] count);
        write_reg(addr_tx_con, '0);
        write_reg(addr_last_flow, reg_w'(last));
        exp_last_flow <= last;
        restart       <= 1'b1;
        @(posedge avmm_clk_ifc);
        restart <= 1'b0;
        write_reg(addr_tx_con, {count, 2'b00, finite, 1'b1});
    endtask

    task automatic wait_packets(input int target, input int limit);
        int waited;
        waited = 0;
        while ((pkt_count < target) && (waited < limit)) begin
            @(posedge avmm_clk_ifc);
            waited++;
        end
        if (pkt_count < target) begin
            $display("Missing frames: %0d packets seen, %0d expected", pkt_count, target);
            tb_errors++;
        end
    endtask

    task automatic expect_idle(input int n);
        int busy;
        busy = 0;
        repeat (n) begin
            @(negedge avmm_clk_ifc);
            if (tvalid) begin
                busy++;
            end
        end
        if (busy != 0) begin
            $display("Stream not idle: tvalid high in %0d of %0d cycles", busy, n);
            tb_errors++;
        end
    endtask

    task automatic check_counter(input logic [addr_w-1:0] lo_addr, input logic [63:0] expected,
                                 input string name);
        logic [reg_w-1:0] lo;
        logic [reg_w-1:0] hi;
        read_reg(lo_addr, lo);
        read_reg(lo_addr + 1'b1, hi);
        if ({hi, lo} != expected) begin
            flag_mismatch($sformatf("%s snapshot %0d, expected %0d", name, {hi, lo}, expected));
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errs);
        if (errs == 0) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, errs);
            tests_failed++;
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [reg_w-1:0] rd;
        int               tb_before;
        int               chk_before;
        int               base;
        int               stop_count;
        int               waited;
        address       = '0;
        write         = 1'b0;
        writedata     = '0;
        read          = 1'b0;
        restart       = 1'b0;
        exp_last_flow = '0;
        random_ready  = 1'b0;
        for (int f = 0; f < NUM_FLOWS; f++) begin
            defs[f] = make_def(f);
        end
        wait (!rst);
        load_flows();

        // Finite run of 40 frames over all flows
        tb_before  = tb_errors;
        chk_before = chk_errors;
        start_run(flow_w'(NUM_FLOWS - 1), 1'b1, 28'd40);
        wait_packets(40, 3000);
        expect_idle(200);
        if (pkt_count != 40) begin
            flag_mismatch($sformatf("%0d packets, expected 40", pkt_count));
        end
        for (int f = 0; f < NUM_FLOWS; f++) begin
            if (flow_seen[f] != 4) begin
                flag_mismatch($sformatf("flow %0d seen %0d times, expected 4", f, flow_seen[f]));
            end
        end
        finish_test(1, "finite run of 40 frames", tb_errors - tb_before);
        finish_test(2, "frame content", chk_errors - chk_before);

        // Random back-pressure on flows 0 to 5
        tb_before    = tb_errors + chk_errors;
        random_ready <= 1'b1;
        start_run(flow_w'(5), 1'b1, 28'd18);
        wait_packets(58, 4000);
        random_ready <= 1'b0;
        expect_idle(200);
        for (int f = 0; f < NUM_FLOWS; f++) begin
            if (flow_seen[f] != ((f <= 5) ? 3 : 0)) begin
                flag_mismatch($sformatf("flow %0d seen %0d times under stalls", f, flow_seen[f]));
            end
        end
        finish_test(3, "back-pressure and round-robin", tb_errors + chk_errors - tb_before);

        tb_before = tb_errors;
        write_reg(addr_cntr_con, 32'd1);
        repeat (2) @(posedge avmm_clk_ifc);
        read_reg(addr_params, rd);
        if (rd != reg_w'(NUM_FLOWS)) begin
            flag_mismatch($sformatf("PARAMS read %0d, expected %0d", rd, NUM_FLOWS));
        end
        check_counter(addr_pkt_cnt0, 64'(pkt_count), "packet");
        check_counter(addr_byte_cnt0, 64'(byte_count), "byte");
        finish_test(4, "counter snapshot", tb_errors - tb_before);

        // Continuous run stopped just after a frame has begun
        tb_before = tb_errors + chk_errors;
        base      = pkt_count;
        start_run(flow_w'(5), 1'b0, 28'd0);
        wait_packets(base + 3, 1000);
        do @(negedge avmm_clk_ifc); while (!(tvalid && tready && tlast));
        do @(negedge avmm_clk_ifc); while (!tvalid);
        write_reg(addr_tx_con, '0);
        stop_count = frame_count;
        waited     = 0;
        while (frame_open && (waited < 500)) begin
            @(posedge avmm_clk_ifc);
            waited++;
        end
        if (frame_open) begin
            $display("Open frame never ended with tlast after the disable");
            tb_errors++;
        end
        expect_idle(200);
        if (frame_count != stop_count) begin
            flag_mismatch($sformatf("%0d frames after disable", frame_count - stop_count));
        end
        finish_test(5, "continuous run stop", tb_errors + chk_errors - tb_before);

        $display("Summary: 5 tests, %0d failed, %0d errors, %0d packets, %0d bytes",
                 tests_failed, tb_errors + chk_errors, pkt_count, byte_count);
        if ((tb_errors + chk_errors) == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
//////////////////////////////
// Testbench clock of 100 ns period and the power-on reset
//////////////////////////////
module tb_clock (
    output logic avmm_clk_ifc,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        avmm_clk_ifc = 1'b0;
        forever #50 avmm_clk_ifc = ~avmm_clk_ifc;
    end

    // Reset held for 10 rising edges
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge avmm_clk_ifc);
        rst <= 1'b0;
    end

endmodule

// File: src/csr_regs.sv
//////////////////////////////
// Register block: flow definition staging, TX control, counter readback
//////////////////////////////
module csr_regs #(
    parameter  int NUM_FLOWS = 10,
    localparam int flow_w    = $clog2(NUM_FLOWS)
) (
    input  logic                           avmm_clk_ifc,
    input  logic                           rst,
    input  logic [pkt_gen_pkg::addr_w-1:0] address,
    input  logic                           write,
    input  logic [pkt_gen_pkg::reg_w-1:0]  writedata,
    input  logic                           read,
    input  logic [63:0]                    pkt_snap,
    input  logic [63:0]                    byte_snap,
    output logic [pkt_gen_pkg::reg_w-1:0]  readdata,
    output logic                           def_we,
    output logic [flow_w-1:0]              def_addr,
    output pkt_gen_pkg::flow_def_u         def_data,
    output logic                           tx_enable,
    output logic                           tx_finite,
    output logic [27:0]                    tx_count,
    output logic [flow_w-1:0]              last_flow,
    output logic                           sample
);
    import pkt_gen_pkg::*;

    flow_def_u         stage;
    logic [addr_w-1:0] stage_idx;
    logic              stage_hit;

    // Lower addresses wrap to large offsets and miss
    assign stage_idx = address - addr_flow_def_data;
    assign stage_hit = (stage_idx < flow_def_words);

    assign def_data = stage;

    //////////////////////////////
    // Control registers
    //////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (rst) begin
            def_we    <= 1'b0;
            sample    <= 1'b0;
            tx_enable <= 1'b0;
            tx_finite <= 1'b0;
            tx_count  <= '0;
            last_flow <= '0;
        end else begin
            def_we <= write && (address == addr_flow_def_con) && writedata[0];
            sample <= write && (address == addr_cntr_con) && writedata[0];
            if (write && (address == addr_tx_con)) begin
                tx_enable <= writedata[0];
                tx_finite <= writedata[1];
                tx_count  <= writedata[31:4];
            end
            if (write && (address == addr_last_flow)) begin
                last_flow <= writedata[flow_w-1:0];
            end
        end
    end

    //////////////////////////////
    // Staging and readback
    //////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (write && stage_hit) begin
            stage.words[stage_idx] <= writedata;
        end
        // Flow id lands together with the def_we pulse
        if (write && (address == addr_flow_def_con)) begin
            def_addr <= writedata[8 +: flow_w];
        end
        if (read) begin
            case (address)
                addr_params:    readdata <= reg_w'(NUM_FLOWS);
                addr_tx_con:    readdata <= {tx_count, 2'b00, tx_finite, tx_enable};
                addr_pkt_cnt0:  readdata <= pkt_snap[31:0];
                addr_pkt_cnt1:  readdata <= pkt_snap[63:32];
                addr_byte_cnt0: readdata <= byte_snap[31:0];
                addr_byte_cnt1: readdata <= byte_snap[63:32];
                addr_last_flow: readdata <= reg_w'(last_flow);
                default:        readdata <= '0;
            endcase
        end
    end

endmodule

// File: src/pkt_gen_top.sv
//////////////////////////////
// Multi-flow Ethernet test-frame generator
// Register port in, 64-bit frame stream out
//////////////////////////////
module pkt_gen_top #(
    parameter  int NUM_FLOWS = 10,
    localparam int flow_w    = $clog2(NUM_FLOWS)
) (
    input  logic                                  avmm_clk_ifc,
    input  logic                                  rst,
    input  logic [pkt_gen_pkg::addr_w-1:0]        address,
    input  logic                                  write,
    input  logic [pkt_gen_pkg::reg_w-1:0]         writedata,
    input  logic                                  read,
    output logic [pkt_gen_pkg::reg_w-1:0]         readdata,
    output logic [pkt_gen_pkg::data_bytes*8-1:0]  tdata,
    output logic [pkt_gen_pkg::data_bytes-1:0]    tkeep,
    output logic                                  tvalid,
    output logic                                  tlast,
    output logic [flow_w-1:0]                     tuser,
    input  logic                                  tready
);
    import pkt_gen_pkg::*;

    logic              def_we;
    logic [flow_w-1:0] def_addr;
    flow_def_u         def_data;
    flow_def_t         def_out;
    logic              tx_enable;
    logic              tx_finite;
    logic [27:0]       tx_count;
    logic [flow_w-1:0] last_flow;
    logic              sample;
    logic [63:0]       pkt_snap;
    logic [63:0]       byte_snap;
    logic              frame_start;
    logic [flow_w-1:0] frame_flow;
    logic              frame_busy;

    csr_regs #(
        .NUM_FLOWS (NUM_FLOWS)
    ) csr_regs_i (
        .avmm_clk_ifc (avmm_clk_ifc),
        .rst          (rst),
        .address      (address),
        .write        (write),
        .writedata    (writedata),
        .read         (read),
        .pkt_snap     (pkt_snap),
        .byte_snap    (byte_snap),
        .readdata     (readdata),
        .def_we       (def_we),
        .def_addr     (def_addr),
        .def_data     (def_data),
        .tx_enable    (tx_enable),
        .tx_finite    (tx_finite),
        .tx_count     (tx_count),
        .last_flow    (last_flow),
        .sample       (sample)
    );

    flow_table #(
        .NUM_FLOWS (NUM_FLOWS)
    ) flow_table_i (
        .avmm_clk_ifc (avmm_clk_ifc),
        .def_we       (def_we),
        .def_addr     (def_addr),
        .def_data     (def_data),
        .rd_addr      (frame_flow),
        .def_out      (def_out)
    );

    flow_sched #(
        .NUM_FLOWS (NUM_FLOWS)
    ) flow_sched_i (
        .avmm_clk_ifc (avmm_clk_ifc),
        .rst          (rst),
        .tx_enable    (tx_enable),
        .tx_finite    (tx_finite),
        .tx_count     (tx_count),
        .last_flow    (last_flow),
        .frame_busy   (frame_busy),
        .frame_start  (frame_start),
        .frame_flow   (frame_flow)
    );

    frame_builder #(
        .NUM_FLOWS (NUM_FLOWS)
    ) frame_builder_i (
        .avmm_clk_ifc (avmm_clk_ifc),
        .rst          (rst),
        .frame_start  (frame_start),
        .frame_flow   (frame_flow),
        .def_in       (def_out),
        .tready       (tready),
        .frame_busy   (frame_busy),
        .tdata        (tdata),
        .tkeep        (tkeep),
        .tvalid       (tvalid),
        .tlast        (tlast),
        .tuser        (tuser)
    );

    tx_counters tx_counters_i (
        .avmm_clk_ifc (avmm_clk_ifc),
        .rst          (rst),
        .tvalid       (tvalid),
        .tready       (tready),
        .tlast        (tlast),
        .tkeep        (tkeep),
        .sample       (sample),
        .pkt_snap     (pkt_snap),
        .byte_snap    (byte_snap)
    );

endmodule

// File: src/tx_counters.sv
//////////////////////////////
// Packet and byte totals of the output stream
//////////////////////////////
module tx_counters (
    input  logic                               avmm_clk_ifc,
    input  logic                               rst,
    input  logic                               tvalid,
    input  logic                               tready,
    input  logic                               tlast,
    input  logic [pkt_gen_pkg::data_bytes-1:0] tkeep,
    input  logic                               sample,
    output logic [63:0]                        pkt_snap,
    output logic [63:0]                        byte_snap
);
    logic [63:0] pkt_total;
    logic [63:0] byte_total;
    logic        beat_ok;

    assign beat_ok = tvalid && tready;

    always_ff @(posedge avmm_clk_ifc) begin
        if (rst) begin
            pkt_total  <= '0;
            byte_total <= '0;
            pkt_snap   <= '0;
            byte_snap  <= '0;
        end else begin
            if (beat_ok) begin
                byte_total <= byte_total + 64'($countones(tkeep));
                if (tlast) begin
                    pkt_total <= pkt_total + 64'd1;
                end
            end
            // Snapshot holds totals up to the cycle before
            if (sample) begin
                pkt_snap  <= pkt_total;
                byte_snap <= byte_total;
            end
        end
    end

endmodule
